// ==== Makefile ====
# Verilator build and run for the erx receiver

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f all.f --top-module erx_tb -Mdir $(OBJ_DIR) -o erx_tb

run: compile
	./$(OBJ_DIR)/erx_tb | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
hdl/erx_pkg.sv
hdl/erx_protocol.sv
hdl/erx_fifo.sv
hdl/erx_disty.sv
hdl/erx.sv
dv/erx_tb.sv

// ==== dv/erx_tb.sv ====
`timescale 1ns/1ps

module erx_tb;

   localparam logic [erx_pkg::ID_W-1:0] OWN_ID = 12'h800; // DUT default chip ID
   localparam int   DEPTH      = 8;                       // DUT default FIFO depth
   localparam int   MAX_CYCLES = 6000;                    // About 200 packets x 14, doubled
   localparam logic [1:0] CH_WR = 2'd0;                   // Channel codes
   localparam logic [1:0] CH_RD = 2'd1;
   localparam logic [1:0] CH_RR = 2'd2;

   logic                       clk;
   logic                       rst_n;
   logic                       rx_frame;
   logic [erx_pkg::BYTE_W-1:0] rx_data;
   logic                       rx_wait;
   logic                       rxwr_access;
   logic                       rxrd_access;
   logic                       rxrr_access;
   logic [erx_pkg::PW-1:0]     rxwr_packet;
   logic [erx_pkg::PW-1:0]     rxrd_packet;
   logic [erx_pkg::PW-1:0]     rxrr_packet;
   logic                       rxwr_wait;
   logic                       rxrd_wait;
   logic                       rxrr_wait;

   integer seed = 32'hb0cf_109e;
   int     cycles = 0;                                    // Timeout counter
   logic   hol_check;                                     // Watch for writes passing a read

   logic [1:0]             exp_order [$];                 // Global order of channels
   logic [erx_pkg::PW-1:0] wr_q [$];                      // Expected per channel
   logic [erx_pkg::PW-1:0] rd_q [$];
   logic [erx_pkg::PW-1:0] rr_q [$];

   erx dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx_frame    (rx_frame),
      .rx_data     (rx_data),
      .rx_wait     (rx_wait),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rxwr_wait   (rxwr_wait),
      .rxrd_access (rxrd_access),
      .rxrd_packet (rxrd_packet),
      .rxrd_wait   (rxrd_wait),
      .rxrr_access (rxrr_access),
      .rxrr_packet (rxrr_packet),
      .rxrr_wait   (rxrr_wait)
   );

   always #4 clk = ~clk;                                  // 8 ns period

   task automatic stop_on_error();
      $display("TESTS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   function automatic string chan_name(input logic [1:0] ch);
      case (ch)
         CH_WR:   return "rxwr";
         CH_RD:   return "rxrd";
         CH_RR:   return "rxrr";
         default: return "none";
      endcase
   endfunction

   task automatic check_packet(input string name, input logic [erx_pkg::PW-1:0] exp,
                               input logic [erx_pkg::PW-1:0] act);
      if (act !== exp) begin
         $display("ERROR time %0t: %s expected %h, actual %h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR time %0t: %s expected %b, actual %b", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("ERROR time %0t: %s expected %0d, actual %0d", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   // Decodes the strobes into a channel and compares it
   task automatic check_channel(input logic [1:0] exp, input logic wr, input logic rd,
                                input logic rr);
      logic [1:0] act;
      int         n;
      n   = int'(wr) + int'(rd) + int'(rr);
      act = wr ? CH_WR : (rd ? CH_RD : CH_RR);
      if (n > 1) begin
         $display("More than one access strobe at time %0t", $time);
         stop_on_error();
      end else if (act !== exp) begin
         $display("ERROR time %0t: access channel expected %s, actual %s",
                  $time, chan_name(exp), chan_name(act));
         stop_on_error();
      end
   endtask

   // Reference routing rule
   function automatic logic [1:0] expected_channel(input logic [erx_pkg::PW-1:0] pkt);
      if (!pkt[erx_pkg::WRITE_BIT]) begin
         return CH_RD;                                    // Reads
      end else if (pkt[erx_pkg::DST_ID_MSB:erx_pkg::DST_ID_LSB] == OWN_ID) begin
         return CH_RR;                                    // Writes to own ID
      end
      return CH_WR;
   endfunction

   task automatic push_expected(input logic [erx_pkg::PW-1:0] pkt);
      logic [1:0] ch;
      ch = expected_channel(pkt);
      exp_order.push_back(ch);
      case (ch)
         CH_WR:   wr_q.push_back(pkt);
         CH_RD:   rd_q.push_back(pkt);
         default: rr_q.push_back(pkt);
      endcase
   endtask

   // Kind 0 read, 1 write to own ID, 2 write elsewhere
   function automatic logic [erx_pkg::PW-1:0] make_packet(input int kind);
      logic [127:0]           raw;
      logic [erx_pkg::PW-1:0] pkt;
      raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
      pkt = raw[erx_pkg::PW-1:0];
      pkt[erx_pkg::WRITE_BIT] = (kind != 0);
      if (kind == 1) begin
         pkt[erx_pkg::DST_ID_MSB:erx_pkg::DST_ID_LSB] = OWN_ID;
      end else if (pkt[erx_pkg::DST_ID_MSB:erx_pkg::DST_ID_LSB] == OWN_ID) begin
         pkt[erx_pkg::DST_ID_LSB] = ~pkt[erx_pkg::DST_ID_LSB]; // Keep away from own ID
      end
      return pkt;
   endfunction

   // Half reads, a third of the writes go home
   function automatic int random_kind();
      if ($unsigned($random(seed)) % 2 == 0) begin
         return 0;
      end
      return ($unsigned($random(seed)) % 3 == 0) ? 1 : 2;
   endfunction

   // Called at a falling edge, leaves at a falling edge
   task automatic drive_bytes(input logic [erx_pkg::PW-1:0] pkt, input int n);
      int i;
      for (i = 0; i < n; i++) begin
         rx_frame = 1'b1;
         rx_data  = pkt[erx_pkg::PW-1-erx_pkg::BYTE_W*i -: erx_pkg::BYTE_W]; // MSB first
         @(negedge clk);
      end
   endtask

   task automatic wait_link_ready();
      if (rx_wait) begin
         rx_frame = 1'b0;                                 // Pause between packets
         while (rx_wait) @(negedge clk);
      end
   endtask

   task automatic send_packet(input logic [erx_pkg::PW-1:0] pkt);
      wait_link_ready();
      push_expected(pkt);
      drive_bytes(pkt, erx_pkg::BYTES_PER_PACKET);
   endtask

   task automatic end_frame();
      rx_frame = 1'b0;
      rx_data  = '0;
      @(negedge clk);
   endtask

   task automatic wait_drain();
      while (exp_order.size() != 0) @(negedge clk);
      repeat (3) @(negedge clk);
   endtask

   // Compares every access strobe with the expected queues
   always @(posedge clk) begin
      logic [1:0] exp_ch;
      if (!rst_n) begin
         check_level("rxwr_access", 1'b0, rxwr_access);
         check_level("rxrd_access", 1'b0, rxrd_access);
         check_level("rxrr_access", 1'b0, rxrr_access);
         check_level("rx_wait", 1'b0, rx_wait);
      end else begin
         if (exp_order.size() > DEPTH + 1) begin          // FIFO plus one on the wire
            $display("More packets outstanding than the FIFO can hold at time %0t", $time);
            stop_on_error();
         end
         if (hol_check && rxrd_wait) begin
            check_level("rxwr_access", 1'b0, rxwr_access); // Writes stuck behind the read
         end
         if (rxwr_access || rxrd_access || rxrr_access) begin
            if (exp_order.size() == 0) begin
               $display("Access at time %0t with no packet expected", $time);
               stop_on_error();
            end else begin
               exp_ch = exp_order.pop_front();
               check_channel(exp_ch, rxwr_access, rxrd_access, rxrr_access);
               case (exp_ch)
                  CH_WR:   check_packet("rxwr_packet", wr_q.pop_front(), rxwr_packet);
                  CH_RD:   check_packet("rxrd_packet", rd_q.pop_front(), rxrd_packet);
                  default: check_packet("rxrr_packet", rr_q.pop_front(), rxrr_packet);
               endcase
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         stop_on_error();
      end
   end

   initial begin
      int i;
      int n;
      clk       = 1'b0;
      rst_n     = 1'b0;
      rx_frame  = 1'b0;
      rx_data   = '0;
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
      hol_check = 1'b0;

      // Reset and the cycles just after it
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_level("rx_wait", 1'b0, rx_wait);
         check_level("rxwr_access", 1'b0, rxwr_access);
         check_level("rxrd_access", 1'b0, rxrd_access);
         check_level("rxrr_access", 1'b0, rxrr_access);
      end

      // Routing with single and back-to-back frames
      for (i = 0; i < 60; i++) begin
         send_packet(make_packet(random_kind()));
         if ($unsigned($random(seed)) % 2 == 0) begin
            end_frame();
         end
      end
      end_frame();
      wait_drain();

      // Aborted frame followed by a good packet
      for (i = 0; i < 4; i++) begin
         n = 1 + int'($unsigned($random(seed)) % 12);
         wait_link_ready();
         drive_bytes(make_packet(random_kind()), n);
         end_frame();
         repeat (5) @(negedge clk);
         send_packet(make_packet(random_kind()));
         end_frame();
         wait_drain();
      end

      // Pushback with the read channel stalled
      rxrd_wait = 1'b1;
      fork
         begin
            send_packet(make_packet(0));                  // Read first so the head blocks
            for (i = 1; i < 20; i++) begin
               send_packet(make_packet(random_kind()));
            end
            end_frame();
         end
         begin
            while (!rx_wait) @(negedge clk);
            repeat (20) @(negedge clk);
            // Sender has paused with a full FIFO
            check_count("fifo_fill", DEPTH, exp_order.size());
            repeat (20) @(negedge clk);
            rxrd_wait = 1'b0;
         end
      join
      wait_drain();

      // Head-of-line blocking, one read then writes
      rxrd_wait = 1'b1;
      hol_check = 1'b1;
      send_packet(make_packet(0));
      end_frame();
      for (i = 0; i < 3; i++) begin
         send_packet(make_packet(2));
         end_frame();
      end
      repeat (30) @(negedge clk);
      rxrd_wait = 1'b0;
      wait_drain();
      hol_check = 1'b0;

      if (exp_order.size() != 0 || wr_q.size() != 0 || rd_q.size() != 0 ||
          rr_q.size() != 0) begin
         $display("Packets missing at the end of the run");
         stop_on_error();
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

// ==== hdl/erx.sv ====
`timescale 1ns/1ps

// Receiver top
// Link bytes go through the assembler, the shared FIFO and then
// the distributor out to the three master channels.
module erx #(
   parameter logic [erx_pkg::ID_W-1:0] ID    = 12'h800, // Own chip ID
   parameter int                       DEPTH = 8         // FIFO packets
) (
   input  logic                       clk,
   input  logic                       rst_n,
   // Link
   input  logic                       rx_frame,
   input  logic [erx_pkg::BYTE_W-1:0] rx_data,
   output logic                       rx_wait,        // Pushback to transmitter
   // Master write
   output logic                       rxwr_access,
   output logic [erx_pkg::PW-1:0]     rxwr_packet,
   input  logic                       rxwr_wait,
   // Master read request
   output logic                       rxrd_access,
   output logic [erx_pkg::PW-1:0]     rxrd_packet,
   input  logic                       rxrd_wait,
   // Read response
   output logic                       rxrr_access,
   output logic [erx_pkg::PW-1:0]     rxrr_packet,
   input  logic                       rxrr_wait
);

   logic                   pkt_valid;                 // Assembler to FIFO
   logic [erx_pkg::PW-1:0] pkt_data;
   logic                   head_valid;                // FIFO to distributor
   logic [erx_pkg::PW-1:0] head_data;
   logic                   pop;

   erx_protocol erx_protocol (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx_frame  (rx_frame),
      .rx_data   (rx_data),
      .pkt_valid (pkt_valid),
      .pkt_data  (pkt_data)
   );

   erx_fifo #(.DEPTH(DEPTH)) erx_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .pkt_valid  (pkt_valid),
      .pkt_data   (pkt_data),
      .pop        (pop),
      .head_valid (head_valid),
      .head_data  (head_data),
      .rx_wait    (rx_wait)
   );

   erx_disty #(.ID(ID)) erx_disty (
      .head_valid  (head_valid),
      .head_data   (head_data),
      .rxwr_wait   (rxwr_wait),
      .rxrd_wait   (rxrd_wait),
      .rxrr_wait   (rxrr_wait),
      .pop         (pop),
      .rxwr_access (rxwr_access),
      .rxrd_access (rxrd_access),
      .rxrr_access (rxrr_access),
      .rxwr_packet (rxwr_packet),
      .rxrd_packet (rxrd_packet),
      .rxrr_packet (rxrr_packet)
   );

endmodule

// ==== hdl/erx_disty.sv ====
`timescale 1ns/1ps

// Routes the FIFO head packet to one master channel
// Reads go to the read request port.
// Writes to this chip ID are read responses coming home,
// and all other writes go to the write port.
module erx_disty #(
   parameter logic [erx_pkg::ID_W-1:0] ID = 12'h800  // Own chip ID
) (
   input  logic                   head_valid,         // FIFO has a packet
   input  logic [erx_pkg::PW-1:0] head_data,          // Oldest packet
   input  logic                   rxwr_wait,
   input  logic                   rxrd_wait,
   input  logic                   rxrr_wait,
   output logic                   pop,                // Head leaves the FIFO
   output logic                   rxwr_access,
   output logic                   rxrd_access,
   output logic                   rxrr_access,
   output logic [erx_pkg::PW-1:0] rxwr_packet,
   output logic [erx_pkg::PW-1:0] rxrd_packet,
   output logic [erx_pkg::PW-1:0] rxrr_packet
);

   logic                     is_write;                // Control byte write flag
   logic [erx_pkg::ID_W-1:0] dst_id;                  // Top of destination address
   logic                     id_match;
   logic                     sel_wr;                  // Channel decode
   logic                     sel_rd;
   logic                     sel_rr;

   assign is_write = head_data[erx_pkg::WRITE_BIT];
   assign dst_id   = head_data[erx_pkg::DST_ID_MSB:erx_pkg::DST_ID_LSB];
   assign id_match = (dst_id == ID);

   assign sel_rd = !is_write;                         // Read request
   assign sel_rr = is_write && id_match;              // Response for us
   assign sel_wr = is_write && !id_match;             // Plain write

   // Only the selected channel can fire, and only when it is ready
   assign rxwr_access = head_valid && sel_wr && !rxwr_wait;
   assign rxrd_access = head_valid && sel_rd && !rxrd_wait;
   assign rxrr_access = head_valid && sel_rr && !rxrr_wait;

   assign pop = rxwr_access || rxrd_access || rxrr_access; // Taken same cycle

   // Same word on every port, access qualifies it
   assign rxwr_packet = head_data;
   assign rxrd_packet = head_data;
   assign rxrr_packet = head_data;

endmodule

// ==== hdl/erx_fifo.sv ====
`timescale 1ns/1ps

// Shared packet buffer between the assembler and the distributor
// One memory for all three channels so a stalled head blocks the rest.
// rx_wait goes up one slot early to cover the packet the
// transmitter may already have in flight.
module erx_fifo #(
   parameter int DEPTH = 8                           // Packets, power of two
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pkt_valid,          // Write strobe
   input  logic [erx_pkg::PW-1:0] pkt_data,           // Write data
   input  logic                   pop,                // Head taken this cycle
   output logic                   head_valid,         // FIFO not empty
   output logic [erx_pkg::PW-1:0] head_data,          // Oldest packet
   output logic                   rx_wait             // Link pushback
);

   localparam int AW = $clog2(DEPTH);                 // Pointer width
   localparam int CW = AW + 1;                        // Count reaches DEPTH

   logic [erx_pkg::PW-1:0] mem [DEPTH];               // Packet storage
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [CW-1:0]          count;                     // Packets held
   logic [CW-1:0]          count_next;

   // Fill level after this edge
   assign count_next = count + CW'(pkt_valid) - CW'(pop);

   // Pointers, count and pushback
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         rx_wait <= 1'b0;
      end else begin
         if (pkt_valid) begin
            wr_ptr <= wr_ptr + 1'b1;                  // Wraps at DEPTH
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count   <= count_next;
         rx_wait <= (count_next >= CW'(DEPTH - 1));   // Tracks count exactly
      end
   end

   // Storage write
   always_ff @(posedge clk) begin
      if (pkt_valid) begin
         mem[wr_ptr] <= pkt_data;
      end
   end

   assign head_valid = (count != '0);                 // Up one cycle after first write
   assign head_data  = mem[rd_ptr];                   // Read straight from memory

endmodule

// ==== hdl/erx_pkg.sv ====
package erx_pkg;

   // Link side
   localparam int BYTE_W           = 8;                        // Bits per link byte
   localparam int BYTES_PER_PACKET = 13;                       // Bytes in one framed packet
   localparam int BCNT_W           = 4;                        // Counts 0 to 12

   // Packet word
   localparam int PW               = BYTES_PER_PACKET * BYTE_W; // 104 bit transaction

   // Packet layout, MSB first on the link
   //   103..72  source or high data
   //    71..40  data
   //    39..8   destination address
   //     7..0   control byte
   localparam int WRITE_BIT        = 0;                        // Write flag in control byte

   // Chip ID sits in the top of the destination address
   localparam int DST_ID_MSB       = 39;                       // Address bit 31
   localparam int DST_ID_LSB       = 28;                       // Address bit 20
   localparam int ID_W             = DST_ID_MSB - DST_ID_LSB + 1; // 12 bit chip ID

endpackage

// ==== hdl/erx_protocol.sv ====
`timescale 1ns/1ps

// Byte stream to packet assembler
// Bytes are taken on every clk edge while rx_frame is high.
// Thirteen such bytes in a row make one packet, and a long frame
// simply carries several packets back to back.
module erx_protocol (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       rx_frame,    // Byte valid level
   input  logic [erx_pkg::BYTE_W-1:0] rx_data,     // Link byte
   output logic                       pkt_valid,   // One cycle per packet
   output logic [erx_pkg::PW-1:0]     pkt_data     // Assembled packet
);

   localparam int SHIFT_LO = erx_pkg::PW - erx_pkg::BYTE_W; // Bits kept on a shift

   // Index of the final byte of a packet
   localparam logic [erx_pkg::BCNT_W-1:0] LAST_BYTE =
      erx_pkg::BCNT_W'(erx_pkg::BYTES_PER_PACKET - 1);

   logic [erx_pkg::BCNT_W-1:0] bcnt;                // Bytes taken so far
   logic                       byte_last;           // Closing byte on the link now

   assign byte_last = rx_frame && (bcnt == LAST_BYTE); // 13th byte of the run

   // Byte counter and packet strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bcnt      <= '0;
         pkt_valid <= 1'b0;
      end else begin
         pkt_valid <= byte_last;                     // Shows the edge after byte 13
         if (!rx_frame) begin
            bcnt <= '0;                              // Frame drop throws away partial
         end else if (byte_last) begin
            bcnt <= '0;                              // Next packet may follow at once
         end else begin
            bcnt <= bcnt + 1'b1;
         end
      end
   end

   // Shift register doubles as the packet output
   // First byte ends up in the top byte after 13 shifts.
   // Leftover bytes from an aborted frame are pushed out
   // before the next packet is flagged.
   always_ff @(posedge clk) begin
      if (rx_frame) begin
         pkt_data <= {pkt_data[SHIFT_LO-1:0], rx_data}; // MSB byte first
      end
   end

   // Note on timing
   // pkt_data is stable for the whole pkt_valid cycle.
   // A new byte in that cycle only lands at the following edge,
   // which is the same edge that writes the packet into the FIFO.

endmodule
